/* snowball_pkg.sv */
package snowball_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // cache index is addr[7:0], 256 one-word lines
  localparam int idx_w = 8;

  // tlb index is addr[15:8]
  localparam int tlb_idx_lo = 8;
  localparam int tlb_idx_w  = 8;

  localparam int vtag_w = 16; // virtual page tag, addr[31:16]
  localparam int ctag_w = 24; // physical addr[31:8]

  // ------------------------------
  // address regions, addr[31:30]
  // ------------------------------
  localparam logic [1:0] region_mem = 2'b00;
  localparam logic [1:0] region_dma = 2'b11;

  // ------------------------------
  // array payloads
  // ------------------------------
  typedef struct packed {
    logic [data_w-1:0] word;
  } line_t;

  typedef struct packed {
    logic              valid;
    logic [ctag_w-1:0] tag;
  } tag_t;

  // same layout as the cpu write data of a tlb write
  typedef struct packed {
    logic [vtag_w-1:0] ptag;  // upper half
    logic [vtag_w-1:0] vtag;  // expected virtual tag
  } tlb_entry_t;

endpackage

/* snowball_ram.sv */
`timescale 1ns/1ps

module snowball_ram #(
  parameter type entry_t = logic [31:0],
  parameter int  depth   = 256
) (
  input  logic                     CPU_CLK,
  input  logic                     re,
  input  logic [$clog2(depth)-1:0] raddr,
  output entry_t                   rdata,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] waddr,
  input  entry_t                   wdata
);

  entry_t mem [depth];

  // all entries start cleared so valid bits read as zero
  initial
  begin
    for (int i = 0; i < depth; i++)
      mem[i] = '0;
  end

  always @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
    if (re)
      rdata <= mem[raddr];  // same-address write gives the old entry
  end

endmodule

/* snowball_tlb.sv */
`timescale 1ns/1ps

module snowball_tlb (
  input  logic                                CPU_CLK,
  input  logic                                RST_CPU,
  // lookup
  input  logic                                re,
  input  logic [snowball_pkg::addr_w-1:0]     rd_addr,
  input  logic                                vmem_act,
  // table write
  input  logic                                wr_en,
  input  logic [snowball_pkg::tlb_idx_w-1:0]  wr_addr,
  input  logic [snowball_pkg::data_w-1:0]     wr_data,
  // result, one cycle after re
  output logic [snowball_pkg::vtag_w-1:0]     ptag,
  output logic                                fault
);

  snowball_pkg::tlb_entry_t         entry_q;
  snowball_pkg::tlb_entry_t         entry_wr;
  logic [snowball_pkg::vtag_w-1:0]  vtag_q;
  logic                             vmem_q;

  assign entry_wr = wr_data;  // ptag high, vtag low

  snowball_ram #(
    .entry_t (snowball_pkg::tlb_entry_t),
    .depth   (2 ** snowball_pkg::tlb_idx_w)
  ) tlb_ram (
    .CPU_CLK (CPU_CLK),
    .re      (re),
    .raddr   (rd_addr[snowball_pkg::tlb_idx_lo +: snowball_pkg::tlb_idx_w]),
    .rdata   (entry_q),
    .we      (wr_en),
    .waddr   (wr_addr),
    .wdata   (entry_wr)
  );

  // ------------------------------
  // side info, in step with the array read
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
      vmem_q <= 1'b0;
    else if (re)
      vmem_q <= vmem_act;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (re)
      vtag_q <= rd_addr[snowball_pkg::addr_w-1 -: snowball_pkg::vtag_w];
  end

  // untranslated when vmem is off
  assign ptag = vmem_q ? entry_q.ptag : vtag_q;

  // stored virtual tag must match the request
  assign fault = vmem_q && (entry_q.vtag != vtag_q);

endmodule

/* snowball_mem_port.sv */
`timescale 1ns/1ps

module snowball_mem_port (
  input  logic                             CPU_CLK,
  input  logic                             RST_CPU,
  // controller side
  input  logic                             xfer_req,
  input  logic                             xfer_we,
  input  logic [snowball_pkg::addr_w-1:0]  xfer_addr,
  input  logic [snowball_pkg::data_w-1:0]  xfer_wdata,
  output logic                             xfer_ack,
  output logic [snowball_pkg::data_w-1:0]  xfer_rdata,
  // main memory
  output logic                             mem_req,
  output logic                             mem_we,
  output logic [snowball_pkg::addr_w-1:0]  mem_addr,
  output logic [snowball_pkg::data_w-1:0]  mem_wdata,
  input  logic                             mem_ack,
  input  logic [snowball_pkg::data_w-1:0]  mem_rdata,
  // dma window, shares mem_addr and mem_wdata
  output logic                             dma_req,
  output logic                             dma_we,
  input  logic                             dma_ack,
  input  logic [snowball_pkg::data_w-1:0]  dma_rdata
);

  typedef enum logic [1:0] {
    st_idle,  // wait for xfer_req
    st_req,   // side req high, wait ack
    st_rel,   // side req low, wait ack low
    st_ack    // xfer_ack high, wait xfer_req low
  } state_t;

  state_t                           state;
  logic [1:0]                       region;
  logic [1:0]                       region_sel;
  logic                             start;
  logic                             start_dma;
  logic                             side_ack;
  logic [snowball_pkg::data_w-1:0]  side_rdata;

  // ------------------------------
  // region decode
  // ------------------------------
  // only 11 is dma, every other code is main memory
  assign region_sel = (xfer_addr[snowball_pkg::addr_w-1 -: 2] == snowball_pkg::region_dma) ?
                      snowball_pkg::region_dma : snowball_pkg::region_mem;

  assign start     = (state == st_idle) && xfer_req;
  assign start_dma = region_sel == snowball_pkg::region_dma;

  // response from whichever side is active
  assign side_ack   = (region == snowball_pkg::region_dma) ? dma_ack : mem_ack;
  assign side_rdata = (region == snowball_pkg::region_dma) ? dma_rdata : mem_rdata;

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state    <= st_idle;
      mem_req  <= 1'b0;
      dma_req  <= 1'b0;
      xfer_ack <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (xfer_req)
          begin
            mem_req <= !start_dma;
            dma_req <= start_dma;
            state   <= st_req;
          end
        st_req:
          if (side_ack)
          begin
            mem_req <= 1'b0;
            dma_req <= 1'b0;
            state   <= st_rel;
          end
        st_rel:
          if (!side_ack)  // side fully released first
          begin
            xfer_ack <= 1'b1;
            state    <= st_ack;
          end
        default:
          if (!xfer_req)
          begin
            xfer_ack <= 1'b0;
            state    <= st_idle;
          end
      endcase
    end
  end

  // address and data held for the whole cycle
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      region    <= region_sel;
      mem_addr  <= xfer_addr;
      mem_wdata <= xfer_wdata;
      mem_we    <= xfer_we && !start_dma;
      dma_we    <= xfer_we && start_dma;
    end
    if ((state == st_req) && side_ack)
      xfer_rdata <= side_rdata;  // capture on ack rise
  end

endmodule

/* snowball_cache_ctrl.sv */
`timescale 1ns/1ps

module snowball_cache_ctrl (
  input  logic                                CPU_CLK,
  input  logic                                RST_CPU,
  // cpu side
  input  logic                                cpu_enable,
  input  logic [snowball_pkg::addr_w-1:0]     cpu_addr,
  input  logic [snowball_pkg::data_w-1:0]     cpu_wdata,
  input  logic                                cpu_we,
  input  logic                                cpu_force_miss,
  input  logic                                cpu_inhibit,
  input  logic                                tlb_we,
  output logic [snowball_pkg::data_w-1:0]     cpu_rdata,
  output logic                                busy,
  output logic                                done,
  output logic                                mmu_fault,
  // translation table
  output logic                                tlb_re,
  output logic [snowball_pkg::addr_w-1:0]     tlb_addr,
  output logic                                tlb_wr_en,
  output logic [snowball_pkg::tlb_idx_w-1:0]  tlb_wr_addr,
  output logic [snowball_pkg::data_w-1:0]     tlb_wr_data,
  input  logic [snowball_pkg::vtag_w-1:0]     tlb_ptag,
  input  logic                                tlb_fault,
  // memory port
  output logic                                xfer_req,
  output logic                                xfer_we,
  output logic [snowball_pkg::addr_w-1:0]     xfer_addr,
  output logic [snowball_pkg::data_w-1:0]     xfer_wdata,
  input  logic                                xfer_ack,
  input  logic [snowball_pkg::data_w-1:0]     xfer_rdata
);

  // lookup stage
  logic                             lk_vld;
  logic [snowball_pkg::addr_w-1:0]  lk_addr;
  logic [snowball_pkg::data_w-1:0]  lk_wdata;
  logic                             lk_we;
  logic                             lk_force;
  logic                             lk_inh;
  logic                             lk_tlb;

  // compare stage
  logic                             cmp_vld;
  logic [snowball_pkg::addr_w-1:0]  cmp_addr;
  logic [snowball_pkg::data_w-1:0]  cmp_wdata;
  logic                             cmp_we;
  logic                             cmp_force;
  logic                             cmp_inh;
  logic                             cmp_tlb;

  logic                             busy_r;
  logic                             x_cache;  // transfer updates the line
  snowball_pkg::line_t              line_q;
  snowball_pkg::tag_t               tag_q;
  snowball_pkg::line_t              line_wr;
  snowball_pkg::tag_t               tag_wr;
  logic                             arr_we;
  logic [snowball_pkg::addr_w-1:0]  phys_addr;
  logic                             hit;
  logic                             cmp_ok;
  logic                             rd_hit;
  logic                             slow;
  logic                             lk_adv;
  logic                             accept;
  logic                             ack_rise;
  logic                             xfer_done;

  // ------------------------------
  // stage control
  // ------------------------------
  assign accept = (cpu_enable || tlb_we) && !busy;

  // lookup stays put while a transfer is pending or starting
  assign lk_adv = lk_vld && !busy_r && !slow;

  // second request in flight behind a miss blocks new ones
  assign busy = busy_r || (lk_vld && slow);

  assign tlb_re      = lk_adv;
  assign tlb_addr    = lk_addr;
  assign tlb_wr_en   = lk_adv && lk_tlb;
  assign tlb_wr_addr = lk_addr[snowball_pkg::tlb_idx_lo +: snowball_pkg::tlb_idx_w];
  assign tlb_wr_data = lk_wdata;

  // ------------------------------
  // compare
  // ------------------------------
  assign phys_addr = {tlb_ptag, cmp_addr[snowball_pkg::addr_w-snowball_pkg::vtag_w-1:0]};

  assign hit = tag_q.valid &&
               (tag_q.tag == phys_addr[snowball_pkg::addr_w-1 -: snowball_pkg::ctag_w]) &&
               !cmp_force && !cmp_inh;

  assign cmp_ok = cmp_vld && !cmp_tlb && !tlb_fault;  // real access, no fault
  assign rd_hit = cmp_ok && !cmp_we && hit;
  assign slow   = cmp_ok && !rd_hit;                  // miss, write or uncached

  // transfer phases
  assign ack_rise  = busy_r && xfer_req && xfer_ack;
  assign xfer_done = busy_r && !xfer_req && !xfer_ack;

  // write-allocate, else fill with the returned word
  assign arr_we       = ack_rise && x_cache;
  assign line_wr.word = xfer_we ? xfer_wdata : xfer_rdata;
  assign tag_wr.valid = 1'b1;
  assign tag_wr.tag   = xfer_addr[snowball_pkg::addr_w-1 -: snowball_pkg::ctag_w];

  snowball_ram #(
    .entry_t (snowball_pkg::line_t),
    .depth   (2 ** snowball_pkg::idx_w)
  ) data_ram (
    .CPU_CLK (CPU_CLK),
    .re      (lk_adv),
    .raddr   (lk_addr[snowball_pkg::idx_w-1:0]),
    .rdata   (line_q),
    .we      (arr_we),
    .waddr   (xfer_addr[snowball_pkg::idx_w-1:0]),
    .wdata   (line_wr)
  );

  snowball_ram #(
    .entry_t (snowball_pkg::tag_t),
    .depth   (2 ** snowball_pkg::idx_w)
  ) tag_ram (
    .CPU_CLK (CPU_CLK),
    .re      (lk_adv),
    .raddr   (lk_addr[snowball_pkg::idx_w-1:0]),
    .rdata   (tag_q),
    .we      (arr_we),
    .waddr   (xfer_addr[snowball_pkg::idx_w-1:0]),
    .wdata   (tag_wr)
  );

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      lk_vld    <= 1'b0;
      cmp_vld   <= 1'b0;
      busy_r    <= 1'b0;
      xfer_req  <= 1'b0;
      done      <= 1'b0;
      mmu_fault <= 1'b0;
    end
    else
    begin
      lk_vld    <= accept || (lk_vld && !lk_adv);
      cmp_vld   <= lk_adv;
      done      <= cmp_vld && !slow;  // hit, fault or tlb write
      mmu_fault <= cmp_vld && !cmp_tlb && tlb_fault;

      if (slow)
      begin
        busy_r   <= 1'b1;
        xfer_req <= 1'b1;
      end
      else if (ack_rise)
        xfer_req <= 1'b0;
      else if (xfer_done)
      begin
        busy_r <= 1'b0;
        done   <= 1'b1;  // held lookup replays next cycle
      end
    end
  end

  // payload
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      lk_addr  <= cpu_addr;
      lk_wdata <= cpu_wdata;
      lk_we    <= cpu_we;
      lk_force <= cpu_force_miss;
      lk_inh   <= cpu_inhibit;
      lk_tlb   <= tlb_we;
    end

    if (lk_adv)
    begin
      cmp_addr  <= lk_addr;
      cmp_wdata <= lk_wdata;
      cmp_we    <= lk_we;
      cmp_force <= lk_force;
      cmp_inh   <= lk_inh;
      cmp_tlb   <= lk_tlb;
    end

    if (slow)
    begin
      xfer_addr  <= phys_addr;
      xfer_we    <= cmp_we;
      xfer_wdata <= cmp_wdata;
      x_cache    <= !cmp_inh;
    end

    // writes leave cpu_rdata as it was
    if (rd_hit)
      cpu_rdata <= line_q.word;
    else if (ack_rise && !xfer_we)
      cpu_rdata <= xfer_rdata;
  end

endmodule

/* snowball_top.sv */
`timescale 1ns/1ps

module snowball_top (
  input  logic                             CPU_CLK,
  input  logic                             RST_CPU,
  // cpu side
  input  logic                             cpu_enable,
  input  logic [snowball_pkg::addr_w-1:0]  cpu_addr,
  input  logic [snowball_pkg::data_w-1:0]  cpu_wdata,
  input  logic                             cpu_we,
  input  logic                             cpu_force_miss,
  input  logic                             cpu_inhibit,
  input  logic                             tlb_we,
  input  logic                             vmem_act,
  output logic [snowball_pkg::data_w-1:0]  cpu_rdata,
  output logic                             busy,
  output logic                             done,
  output logic                             mmu_fault,
  // memory side
  output logic                             mem_req,
  output logic                             mem_we,
  output logic [snowball_pkg::addr_w-1:0]  mem_addr,
  output logic [snowball_pkg::data_w-1:0]  mem_wdata,
  input  logic                             mem_ack,
  input  logic [snowball_pkg::data_w-1:0]  mem_rdata,
  output logic                             dma_req,
  output logic                             dma_we,
  input  logic                             dma_ack,
  input  logic [snowball_pkg::data_w-1:0]  dma_rdata
);

  // controller to tlb
  logic                                tlb_re;
  logic [snowball_pkg::addr_w-1:0]     tlb_addr;
  logic                                tlb_wr_en;
  logic [snowball_pkg::tlb_idx_w-1:0]  tlb_wr_addr;
  logic [snowball_pkg::data_w-1:0]     tlb_wr_data;
  logic [snowball_pkg::vtag_w-1:0]     tlb_ptag;
  logic                                tlb_fault;

  // controller to memory port
  logic                                xfer_req;
  logic                                xfer_we;
  logic [snowball_pkg::addr_w-1:0]     xfer_addr;
  logic [snowball_pkg::data_w-1:0]     xfer_wdata;
  logic                                xfer_ack;
  logic [snowball_pkg::data_w-1:0]     xfer_rdata;

  snowball_cache_ctrl ctrl0 (.*);

  snowball_tlb tlb0 (
    .CPU_CLK  (CPU_CLK),
    .RST_CPU  (RST_CPU),
    .re       (tlb_re),
    .rd_addr  (tlb_addr),
    .vmem_act (vmem_act),
    .wr_en    (tlb_wr_en),
    .wr_addr  (tlb_wr_addr),
    .wr_data  (tlb_wr_data),
    .ptag     (tlb_ptag),
    .fault    (tlb_fault)
  );

  snowball_mem_port port0 (.*);

endmodule

/* snowball_mem_model.sv */
`timescale 1ns/1ps

module snowball_mem_model (
  input  logic                             CPU_CLK,
  input  logic                             mem_req,
  input  logic                             mem_we,
  input  logic [snowball_pkg::addr_w-1:0]  mem_addr,
  input  logic [snowball_pkg::data_w-1:0]  mem_wdata,
  output logic                             mem_ack,
  output logic [snowball_pkg::data_w-1:0]  mem_rdata,
  input  logic                             dma_req,
  input  logic                             dma_we,
  output logic                             dma_ack,
  output logic [snowball_pkg::data_w-1:0]  dma_rdata,
  output int                               mem_count,
  output int                               dma_count,
  output logic                             handshake_err
);

  // sparse store, one entry per write, newest wins
  logic [snowball_pkg::addr_w-1:0]  log_addr [$];
  logic [snowball_pkg::data_w-1:0]  log_data [$];
  logic                             log_dma  [$];
  logic                             side_dma;

  function automatic logic [31:0] stored_word(input logic dma, input logic [31:0] addr);
    logic [31:0] word;
    word = dma ? {addr[15:0], addr[31:16]} : ~addr;  // fill from the whole address
    foreach (log_addr[i])
      if (log_dma[i] == dma && log_addr[i] == addr)
        word = log_data[i];
    return word;
  endfunction

  task automatic random_delay();
    int n;
    n = 1 + ($urandom % 6);  // 1 to 6 cycles
    repeat (n) @(posedge CPU_CLK);
  endtask

  task automatic wait_req_low(input logic dma);
    int n;
    n = 0;
    while ((dma ? dma_req : mem_req) && n < 100)
    begin
      @(posedge CPU_CLK);
      n++;
    end
    if (dma ? dma_req : mem_req)
      handshake_err = 1'b1;  // req never released
  endtask

  initial
  begin
    mem_ack       = 1'b0;
    mem_rdata     = '0;
    dma_ack       = 1'b0;
    dma_rdata     = '0;
    mem_count     = 0;
    dma_count     = 0;
    handshake_err = 1'b0;
    void'($urandom(32'h42b0_1fbc));
    forever
    begin
      @(posedge CPU_CLK);
      if (mem_req || dma_req)
      begin
        side_dma = dma_req;
        if (side_dma)
          dma_count++;
        else
          mem_count++;
        random_delay();
        if (side_dma ? dma_we : mem_we)
        begin
          log_addr.push_back(mem_addr);  // dma shares the address bus
          log_data.push_back(mem_wdata);
          log_dma.push_back(side_dma);
        end
        if (side_dma)
        begin
          dma_rdata <= stored_word(1'b1, mem_addr);
          dma_ack   <= 1'b1;
        end
        else
        begin
          mem_rdata <= stored_word(1'b0, mem_addr);
          mem_ack   <= 1'b1;
        end
        wait_req_low(side_dma);
        random_delay();
        mem_ack <= 1'b0;
        dma_ack <= 1'b0;
      end
    end
  end

endmodule

/* snowball_tb.sv */
`timescale 1ns/1ps

module snowball_tb;

  localparam int max_rows   = 32;
  localparam int wait_limit = 200;

  // row kinds
  localparam int k_read      = 0;
  localparam int k_write     = 1;
  localparam int k_tlb       = 2;
  localparam int k_read_pair = 3;  // this read and the next one back to back

  logic                             CPU_CLK;
  logic                             RST_CPU;
  logic                             cpu_enable;
  logic [snowball_pkg::addr_w-1:0]  cpu_addr;
  logic [snowball_pkg::data_w-1:0]  cpu_wdata;
  logic                             cpu_we;
  logic                             cpu_force_miss;
  logic                             cpu_inhibit;
  logic                             tlb_we;
  logic                             vmem_act;
  logic [snowball_pkg::data_w-1:0]  cpu_rdata;
  logic                             busy;
  logic                             done;
  logic                             mmu_fault;
  logic                             mem_req;
  logic                             mem_we;
  logic [snowball_pkg::addr_w-1:0]  mem_addr;
  logic [snowball_pkg::data_w-1:0]  mem_wdata;
  logic                             mem_ack;
  logic [snowball_pkg::data_w-1:0]  mem_rdata;
  logic                             dma_req;
  logic                             dma_we;
  logic                             dma_ack;
  logic [snowball_pkg::data_w-1:0]  dma_rdata;
  int                               mem_count;
  int                               dma_count;
  logic                             handshake_err;

  // ------------------------------
  // operation table
  // ------------------------------
  string        row_name  [max_rows];
  int           row_kind  [max_rows];
  logic [31:0]  row_addr  [max_rows];
  logic [31:0]  row_wdata [max_rows];
  logic         row_force [max_rows];
  logic         row_inh   [max_rows];
  logic         row_vmem  [max_rows];
  logic [31:0]  row_data  [max_rows];
  logic         row_fault [max_rows];
  int           row_mem   [max_rows];
  int           row_dma   [max_rows];
  int           num_rows;

  snowball_top dut0 (.*);

  snowball_mem_model model0 (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #2 CPU_CLK = ~CPU_CLK;
  end

  task automatic add_row(input string name, input int kind, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic force_miss, input logic inh,
                         input logic vmem, input logic [31:0] data, input logic fault,
                         input int mem_n, input int dma_n);
    row_name[num_rows]  = name;
    row_kind[num_rows]  = kind;
    row_addr[num_rows]  = addr;
    row_wdata[num_rows] = wdata;
    row_force[num_rows] = force_miss;
    row_inh[num_rows]   = inh;
    row_vmem[num_rows]  = vmem;
    row_data[num_rows]  = data;
    row_fault[num_rows] = fault;
    row_mem[num_rows]   = mem_n;
    row_dma[num_rows]   = dma_n;
    num_rows++;
  endtask

  // memory fill is ~addr and dma fill swaps the address halves
  task automatic load_table();
    num_rows = 0;
    add_row("rd_miss", k_read, 32'h0000_1004, 32'h0, 0, 0, 0, 32'hffff_effb, 0, 1, 0);
    add_row("rd_hit", k_read, 32'h0000_1004, 32'h0, 0, 0, 0, 32'hffff_effb, 0, 1, 0);
    add_row("wr_alloc", k_write, 32'h0000_2010, 32'hcafe_0001, 0, 0, 0, 32'hffff_effb, 0, 2, 0);
    add_row("rd_after_wr", k_read, 32'h0000_2010, 32'h0, 0, 0, 0, 32'hcafe_0001, 0, 2, 0);
    add_row("force_miss", k_read, 32'h0000_1004, 32'h0, 1, 0, 0, 32'hffff_effb, 0, 3, 0);
    add_row("inh_present", k_read, 32'h0000_2010, 32'h0, 0, 1, 0, 32'hcafe_0001, 0, 4, 0);
    add_row("inh_absent", k_read, 32'h0000_3020, 32'h0, 0, 1, 0, 32'hffff_cfdf, 0, 5, 0);
    add_row("rd_still_absent", k_read, 32'h0000_3020, 32'h0, 0, 0, 0, 32'hffff_cfdf, 0, 6, 0);
    add_row("rd_now_present", k_read, 32'h0000_3020, 32'h0, 0, 0, 0, 32'hffff_cfdf, 0, 6, 0);
    add_row("dma_rd", k_read, 32'hc000_0040, 32'h0, 0, 0, 0, 32'h0040_c000, 0, 6, 1);
    add_row("dma_wr", k_write, 32'hc000_0044, 32'h1234_5678, 0, 0, 0, 32'h0040_c000, 0, 6, 2);
    add_row("dma_rd_inh", k_read, 32'hc000_0044, 32'h0, 0, 1, 0, 32'h1234_5678, 0, 6, 3);
    add_row("region_10_mem", k_read, 32'h8000_0050, 32'h0, 0, 0, 0, 32'h7fff_ffaf, 0, 7, 3);
    add_row("tlb_wr", k_tlb, 32'h0000_1200, 32'h0055_00ab, 0, 0, 1, 32'h7fff_ffaf, 0, 7, 3);
    add_row("vm_rd_miss", k_read, 32'h00ab_1234, 32'h0, 0, 0, 1, 32'hffaa_edcb, 0, 8, 3);
    add_row("vm_fault", k_read, 32'h00cd_1234, 32'h0, 0, 0, 1, 32'hffaa_edcb, 1, 8, 3);
    add_row("vm_rd_hit", k_read, 32'h00ab_1234, 32'h0, 0, 0, 1, 32'hffaa_edcb, 0, 8, 3);
    add_row("pair_first", k_read_pair, 32'h0000_1004, 32'h0, 0, 0, 0, 32'hffff_effb, 0, 8, 3);
    add_row("pair_second", k_read, 32'h0000_2010, 32'h0, 0, 0, 0, 32'hcafe_0001, 0, 8, 3);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("error: %s %s expected %h actual %h", name, what, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string name, input string what);
    $display("row %s: %s did not happen within %0d cycles", name, what, wait_limit);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic wait_not_busy(input int i);
    int n;
    n = 0;
    while (busy && n < wait_limit)
    begin
      @(negedge CPU_CLK);
      n++;
    end
    if (busy)
      stop_on_timeout(row_name[i], "busy release");
  endtask

  task automatic wait_done(input int i);
    int n;
    n = 0;
    do
    begin
      @(negedge CPU_CLK);
      n++;
    end
    while (!done && n < wait_limit);
    if (!done)
      stop_on_timeout(row_name[i], "done");
  endtask

  task automatic drive_row(input int i);
    cpu_enable     <= row_kind[i] != k_tlb;
    tlb_we         <= row_kind[i] == k_tlb;
    cpu_we         <= row_kind[i] == k_write;
    cpu_addr       <= row_addr[i];
    cpu_wdata      <= row_wdata[i];
    cpu_force_miss <= row_force[i];
    cpu_inhibit    <= row_inh[i];
    vmem_act       <= row_vmem[i];  // held until the next row
  endtask

  task automatic check_row(input int i);
    check_value(row_name[i], "cpu_rdata", row_data[i], cpu_rdata);
    check_value(row_name[i], "mmu_fault", row_fault[i], mmu_fault);
    check_value(row_name[i], "busy", 32'h0, busy);  // busy drops with done
    check_value(row_name[i], "mem requests", row_mem[i], mem_count);
    check_value(row_name[i], "dma requests", row_dma[i], dma_count);
    check_value(row_name[i], "handshake error", 32'h0, handshake_err);
  endtask

  task automatic run_single(input int i);
    wait_not_busy(i);
    @(posedge CPU_CLK);
    drive_row(i);
    @(posedge CPU_CLK);  // accepted here
    cpu_enable <= 1'b0;
    tlb_we     <= 1'b0;
    wait_done(i);
    check_row(i);
  endtask

  // two hits with each done exactly 2 cycles after its acceptance
  task automatic run_pair(input int i);
    wait_not_busy(i);
    @(posedge CPU_CLK);
    drive_row(i);
    @(posedge CPU_CLK);
    drive_row(i + 1);
    @(posedge CPU_CLK);
    cpu_enable <= 1'b0;
    @(negedge CPU_CLK);
    check_value(row_name[i], "early done", 32'h0, done);
    @(negedge CPU_CLK);
    check_value(row_name[i], "done", 32'h1, done);
    check_row(i);
    @(negedge CPU_CLK);
    check_value(row_name[i + 1], "done", 32'h1, done);
    check_row(i + 1);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    int row;
    RST_CPU        = 1'b1;
    cpu_enable     = 1'b0;
    cpu_addr       = '0;
    cpu_wdata      = '0;
    cpu_we         = 1'b0;
    cpu_force_miss = 1'b0;
    cpu_inhibit    = 1'b0;
    tlb_we         = 1'b0;
    vmem_act       = 1'b0;
    load_table();
    repeat (8) @(posedge CPU_CLK);
    RST_CPU <= 1'b0;
    @(negedge CPU_CLK);
    // idle out of reset
    check_value("reset", "busy", 32'h0, busy);
    check_value("reset", "done", 32'h0, done);
    check_value("reset", "mmu_fault", 32'h0, mmu_fault);
    check_value("reset", "mem_req", 32'h0, mem_req);
    check_value("reset", "dma_req", 32'h0, dma_req);
    row = 0;
    while (row < num_rows)
    begin
      if (row_kind[row] == k_read_pair)
      begin
        run_pair(row);
        row += 2;
      end
      else
      begin
        run_single(row);
        row++;
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* sim.f */
snowball_pkg.sv
snowball_ram.sv
snowball_tlb.sv
snowball_mem_port.sv
snowball_cache_ctrl.sv
snowball_top.sv
snowball_mem_model.sv
snowball_tb.sv

/* Bender.yml */
package:
  name: snowball

sources:
  - snowball_pkg.sv
  - snowball_ram.sv
  - snowball_tlb.sv
  - snowball_mem_port.sv
  - snowball_cache_ctrl.sv
  - snowball_top.sv
  - target: test
    files:
      - snowball_mem_model.sv
      - snowball_tb.sv
